// File: build.f
+incdir+logic
logic/cpu_pkg.sv
logic/fetch_stage.sv
logic/id.sv
logic/regfile.sv
logic/execute_stage.sv
logic/cpu_top.sv
tb/tb_clkgen.sv
tb/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_top
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps

BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard logic/*.sv logic/*.svh tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: tb/tb_top.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module tb_top import cpu_pkg::*; ();

localparam int ROM_WORDS = 256;
localparam int PROG_LEN = 224;
localparam int RESET_CYCLES = 16;
localparam int DRAIN_CYCLES = 8;
localparam int CE_TIMEOUT = 8;
localparam int RUN_CYCLES = PROG_LEN + 4 + DRAIN_CYCLES;
localparam int WATCHDOG_CYCLES = RESET_CYCLES + CE_TIMEOUT + RUN_CYCLES + 64;

logic						clk;
logic						reset_i;
logic						rom_ce;
logic [`CPU_PC_W-1:0]		rom_addr;
logic [`CPU_INST_W-1:0]	rom_data;
wb_t						wb;

logic [`CPU_INST_W-1:0]	rom [ROM_WORDS];
logic [`CPU_DATA_W-1:0]	model_regs [`CPU_REG_NUM];
logic						exp_we [$];	// one entry per instruction
wb_t						exp_q [$];	// expected writes in program order

tb_clkgen u_clkgen (
	.clk_o			(clk)
);

cpu_top u_cpu_top (
	.clk			(clk),
	.reset_i		(reset_i),
	.rom_ce_o		(rom_ce),
	.rom_addr_o		(rom_addr),
	.rom_data_i		(rom_data),
	.wb_o			(wb)
);

// Words past the ROM read as NOP
assign rom_data = (rom_addr[`CPU_PC_W-1:10] == '0) ? rom[rom_addr[9:2]] : '0;

task automatic stop_on_failure(input string msg);
	$display("%s", msg);
	$display("tests failed");
	$fatal(1);
endtask

task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
	stop_on_failure($sformatf("ERROR: %s = 0x%h, expected 0x%h", name, got, exp));
endtask

function automatic logic [4:0] rand_reg();
	return 5'($urandom_range(7, 0));		// small set keeps dependencies close
endfunction

function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] rtype_word(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [5:0] funct);
	return {6'b000000, rs, rt, rd, 5'b00000, funct};
endfunction

// Random program and the architectural result of every instruction
task automatic build_program();
	logic [4:0]		rs;
	logic [4:0]		rt;
	logic [4:0]		rd;
	logic [4:0]		dest;
	logic [15:0]	imm;
	logic [31:0]	a;
	logic [31:0]	b;
	logic [31:0]	word;
	logic [31:0]	result;
	logic			writes;
	wb_t			wr;
	int				kind;

	for (int i = 0; i < ROM_WORDS; i++) begin
		rom[8'(i)] = '0;
	end
	for (int i = 0; i < `CPU_REG_NUM; i++) begin
		model_regs[5'(i)] = '0;
	end
	for (int i = 0; i < PROG_LEN; i++) begin
		kind = int'($urandom_range(16, 0));
		rs = rand_reg();
		rt = rand_reg();
		rd = rand_reg();
		imm = 16'($urandom);
		a = (rs == '0) ? '0 : model_regs[rs];
		b = (rt == '0) ? '0 : model_regs[rt];
		writes = 1'b1;
		dest = rt;
		case (kind)
			0, 1: begin
				word = itype_word(OP_ANDI, rs, rt, imm);
				result = a & {16'h0, imm};
			end
			2, 3: begin
				word = itype_word(OP_ORI, rs, rt, imm);
				result = a | {16'h0, imm};
			end
			4, 5: begin
				word = itype_word(OP_XORI, rs, rt, imm);
				result = a ^ {16'h0, imm};
			end
			6, 7: begin
				word = itype_word(OP_LUI, rs, rt, imm);
				result = {imm, 16'h0};		// rs field plays no part
			end
			8, 9: begin
				word = rtype_word(rs, rt, rd, FN_AND);
				dest = rd;
				result = a & b;
			end
			10, 11: begin
				word = rtype_word(rs, rt, rd, FN_OR);
				dest = rd;
				result = a | b;
			end
			12, 13: begin
				word = rtype_word(rs, rt, rd, FN_XOR);
				dest = rd;
				result = a ^ b;
			end
			14, 15: begin
				word = rtype_word(rs, rt, rd, FN_NOR);
				dest = rd;
				result = ~(a | b);
			end
			default: begin
				// Opcodes 0x10 and up are outside the supported set
				word = itype_word(6'($urandom_range(63, 16)), rs, rt, imm);
				writes = 1'b0;
				result = '0;
			end
		endcase
		rom[8'(i)] = word;
		if (writes && dest != '0) begin
			model_regs[dest] = result;
			wr.we = 1'b1;
			wr.addr = dest;
			wr.data = result;
			exp_q.push_back(wr);
			exp_we.push_back(1'b1);
		end else begin
			exp_we.push_back(1'b0);
		end
	end
endtask

initial begin
	for (int i = 0; i < WATCHDOG_CYCLES; i++) begin
		@(posedge clk);
	end
	stop_on_failure("simulation did not finish within the cycle limit");
end

initial begin
	int						wait_cycles;
	logic [`CPU_PC_W-1:0]	exp_pc;
	logic					exp_wen;
	wb_t					exp_wr;

	reset_i = 1'b1;
	void'($urandom(32'hbb7fbeac));
	build_program();

	repeat (RESET_CYCLES) @(posedge clk);
	@(negedge clk);
	assert (!rom_ce) else stop_on_failure("rom_ce_o is high while reset is held");
	assert (!wb.we) else stop_on_failure("wb_o writes a register while reset is held");
	reset_i = 1'b0;

	wait_cycles = 0;
	while (!rom_ce) begin
		@(negedge clk);
		wait_cycles++;
		if (wait_cycles > CE_TIMEOUT) begin
			stop_on_failure("timeout waiting for rom_ce_o after reset release");
		end
	end

	// Cycle c fetches word c and retires instruction c-4
	exp_pc = `CPU_RESET_PC;
	for (int c = 0; c < RUN_CYCLES; c++) begin
		assert (rom_ce) else stop_on_failure("rom_ce_o dropped while fetching");
		assert (rom_addr == exp_pc) else report_mismatch("rom_addr_o", rom_addr, exp_pc);
		exp_wen = (c >= 4 && c - 4 < PROG_LEN) ? exp_we[c - 4] : 1'b0;
		assert (wb.we == exp_wen) else report_mismatch("wb_o.we", 32'(wb.we), 32'(exp_wen));
		if (wb.we) begin
			exp_wr = exp_q.pop_front();
			assert (wb.addr == exp_wr.addr)
				else report_mismatch("wb_o.addr", 32'(wb.addr), 32'(exp_wr.addr));
			assert (wb.data == exp_wr.data)
				else report_mismatch("wb_o.data", wb.data, exp_wr.data);
		end
		exp_pc = exp_pc + `CPU_PC_W'(4);
		@(negedge clk);
	end

	$display("all tests passed");
	$finish;
end

endmodule

// File: tb/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
	parameter int HALF_NS = 5		// 10 ns period
) (
	output	logic	clk_o
);

initial begin
	clk_o = 1'b0;
	forever begin
		#(HALF_NS) clk_o = ~clk_o;
	end
end

endmodule

// File: logic/cpu_top.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_top import cpu_pkg::*; (
	input	logic						clk,
	input	logic						reset_i,

	// instruction memory
	output	logic						rom_ce_o,
	output	logic [`CPU_PC_W-1:0]		rom_addr_o,
	input	logic [`CPU_INST_W-1:0]	rom_data_i,

	// retired register write
	output	wb_t						wb_o
);

if_id_t						if_id;
rd_port_t					rd1;
rd_port_t					rd2;
logic [`CPU_DATA_W-1:0]	rd1_data;
logic [`CPU_DATA_W-1:0]	rd2_data;
wb_t						ex_fwd;
wb_t						mem_fwd;
id_ex_t						id_ex;

fetch_stage u_fetch (
	.clk			(clk),
	.reset_i		(reset_i),
	.rom_ce_o		(rom_ce_o),
	.rom_addr_o		(rom_addr_o),
	.rom_data_i		(rom_data_i),
	.if_id_o		(if_id)
);

id u_id (
	.if_id_i		(if_id),
	.rd1_o			(rd1),
	.rd2_o			(rd2),
	.rd1_data_i		(rd1_data),
	.rd2_data_i		(rd2_data),
	.ex_fwd_i		(ex_fwd),
	.mem_fwd_i		(mem_fwd),
	.id_ex_o		(id_ex)
);

regfile u_regfile (
	.clk			(clk),
	.reset_i		(reset_i),
	.rd1_i			(rd1),
	.rd2_i			(rd2),
	.rd1_data_o		(rd1_data),
	.rd2_data_o		(rd2_data),
	.wr_i			(wb_o)			// write-back also drives the top output
);

execute_stage u_execute (
	.clk			(clk),
	.reset_i		(reset_i),
	.id_ex_i		(id_ex),
	.ex_fwd_o		(ex_fwd),
	.mem_fwd_o		(mem_fwd),
	.wb_o			(wb_o)
);

endmodule

// File: logic/execute_stage.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module execute_stage import cpu_pkg::*; (
	input	logic		clk,
	input	logic		reset_i,

	// from decode
	input	id_ex_t		id_ex_i,

	// forwarding taps back to decode
	output	wb_t		ex_fwd_o,
	output	wb_t		mem_fwd_o,

	// to regfile write port
	output	wb_t		wb_o
);

id_ex_t						ex_q;
wb_t						mem_q;
wb_t						wb_q;
logic [`CPU_DATA_W-1:0]	result;

// Decode/execute register
always_ff @(posedge clk) begin
	if (reset_i) begin
		ex_q <= '0;				// ALU_NOP with no write
	end else begin
		ex_q <= id_ex_i;
	end
end

always_comb begin
	case (ex_q.alu_op)
		ALU_AND: result = ex_q.op1 & ex_q.op2;
		ALU_OR: result = ex_q.op1 | ex_q.op2;
		ALU_XOR: result = ex_q.op1 ^ ex_q.op2;
		ALU_NOR: result = ~(ex_q.op1 | ex_q.op2);
		default: result = '0;
	endcase
end

always_comb begin
	ex_fwd_o.we = ex_q.we;
	ex_fwd_o.addr = ex_q.wd;
	ex_fwd_o.data = result;
end

// Execute/memory register that the memory stage only passes on
always_ff @(posedge clk) begin
	if (reset_i) begin
		mem_q.we <= 1'b0;
		mem_q.addr <= '0;
		mem_q.data <= '0;
	end else begin
		mem_q <= ex_fwd_o;
	end
end

// Memory/write-back register
always_ff @(posedge clk) begin
	if (reset_i) begin
		wb_q.we <= 1'b0;
		wb_q.addr <= '0;
		wb_q.data <= '0;
	end else begin
		wb_q <= mem_q;
	end
end

assign mem_fwd_o = mem_q;
assign wb_o = wb_q;

endmodule

// File: logic/regfile.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module regfile import cpu_pkg::*; (
	input	logic						clk,
	input	logic						reset_i,

	// read ports
	input	rd_port_t					rd1_i,
	input	rd_port_t					rd2_i,
	output	logic [`CPU_DATA_W-1:0]	rd1_data_o,
	output	logic [`CPU_DATA_W-1:0]	rd2_data_o,

	// write port from write-back
	input	wb_t						wr_i
);

logic [`CPU_DATA_W-1:0] regs [`CPU_REG_NUM];

always_ff @(posedge clk) begin
	if (reset_i) begin
		for (int i = 0; i < `CPU_REG_NUM; i++) begin
			regs[i] <= '0;
		end
	end else if (wr_i.we && wr_i.addr != '0) begin
		regs[wr_i.addr] <= wr_i.data;
	end
end

// Same-cycle write is returned directly
function automatic logic [`CPU_DATA_W-1:0] read_port(
	input rd_port_t					port,
	input wb_t						wr,
	input logic [`CPU_DATA_W-1:0]	stored
);
	if (!port.en || port.addr == '0) begin
		return '0;
	end else if (wr.we && wr.addr == port.addr) begin
		return wr.data;
	end
	return stored;
endfunction

always_comb begin
	rd1_data_o = read_port(rd1_i, wr_i, regs[rd1_i.addr]);
end

always_comb begin
	rd2_data_o = read_port(rd2_i, wr_i, regs[rd2_i.addr]);
end

endmodule

// File: logic/id.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module id import cpu_pkg::*; (
	input	if_id_t						if_id_i,

	// to regfile
	output	rd_port_t					rd1_o,
	output	rd_port_t					rd2_o,

	// from regfile
	input	logic [`CPU_DATA_W-1:0]	rd1_data_i,
	input	logic [`CPU_DATA_W-1:0]	rd2_data_i,

	// forwarding from execute and memory
	input	wb_t						ex_fwd_i,
	input	wb_t						mem_fwd_i,

	// to execute
	output	id_ex_t						id_ex_o
);

opcode_e						op;
funct_e							funct;
logic [`CPU_REG_ADDR_W-1:0]	rs;
logic [`CPU_REG_ADDR_W-1:0]	rt;
logic [`CPU_REG_ADDR_W-1:0]	rd;
logic [15:0]					imm16;

alu_op_e						alu_op;
logic [`CPU_DATA_W-1:0]		imm;
logic							rd1_en;
logic							rd2_en;
logic [`CPU_REG_ADDR_W-1:0]	rd1_addr;
logic [`CPU_REG_ADDR_W-1:0]	wd;
logic							wreg;

assign op = opcode_e'(if_id_i.inst[`CPU_OP_HI:`CPU_OP_LO]);
assign rs = if_id_i.inst[`CPU_RS_HI:`CPU_RS_LO];
assign rt = if_id_i.inst[`CPU_RT_HI:`CPU_RT_LO];
assign rd = if_id_i.inst[`CPU_RD_HI:`CPU_RD_LO];
assign funct = funct_e'(if_id_i.inst[5:0]);
assign imm16 = if_id_i.inst[15:0];

always_comb begin
	alu_op = ALU_NOP;
	imm = '0;
	rd1_en = 1'b0;
	rd2_en = 1'b0;
	rd1_addr = rs;
	wd = rd;
	wreg = 1'b0;

	case (op)
		OP_SPECIAL: begin
			rd1_en = 1'b1;
			rd2_en = 1'b1;
			wreg = 1'b1;
			case (funct)
				FN_AND: alu_op = ALU_AND;
				FN_OR: alu_op = ALU_OR;
				FN_XOR: alu_op = ALU_XOR;
				FN_NOR: alu_op = ALU_NOR;
				default: wreg = 1'b0;		// Unknown function writes nothing
			endcase
		end
		OP_ANDI, OP_ORI, OP_XORI: begin
			rd1_en = 1'b1;
			imm = {16'h0, imm16};
			wd = rt;
			wreg = 1'b1;
			alu_op = (op == OP_ANDI) ? ALU_AND : (op == OP_ORI) ? ALU_OR : ALU_XOR;
		end
		OP_LUI: begin
			// Immediate goes to the upper half and is ORed with r0
			rd1_en = 1'b1;
			rd1_addr = '0;
			imm = {imm16, 16'h0};
			wd = rt;
			wreg = 1'b1;
			alu_op = ALU_OR;
		end
		default: begin
		end
	endcase
end

// Operand priority runs immediate, r0, execute, memory, then regfile
function automatic logic [`CPU_DATA_W-1:0] pick_operand(
	input rd_port_t					port,
	input logic [`CPU_DATA_W-1:0]	reg_data,
	input logic [`CPU_DATA_W-1:0]	imm_val,
	input wb_t						ex_tap,
	input wb_t						mem_tap
);
	if (!port.en) begin
		return imm_val;
	end else if (port.addr == '0) begin
		return '0;
	end else if (ex_tap.we && ex_tap.addr == port.addr) begin
		return ex_tap.data;
	end else if (mem_tap.we && mem_tap.addr == port.addr) begin
		return mem_tap.data;
	end
	return reg_data;			// regfile already bypasses write-back
endfunction

always_comb begin
	rd1_o.en = rd1_en;
	rd1_o.addr = rd1_addr;
	rd2_o.en = rd2_en;
	rd2_o.addr = rt;
end

always_comb begin
	id_ex_o.alu_op = alu_op;
	id_ex_o.op1 = pick_operand(rd1_o, rd1_data_i, imm, ex_fwd_i, mem_fwd_i);
	id_ex_o.op2 = pick_operand(rd2_o, rd2_data_i, imm, ex_fwd_i, mem_fwd_i);
	id_ex_o.wd = wd;
	id_ex_o.we = wreg && (wd != '0);		// r0 is never written
end

endmodule

// File: logic/fetch_stage.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module fetch_stage import cpu_pkg::*; (
	input	logic						clk,
	input	logic						reset_i,

	// instruction memory
	output	logic						rom_ce_o,
	output	logic [`CPU_PC_W-1:0]		rom_addr_o,
	input	logic [`CPU_INST_W-1:0]	rom_data_i,

	// to decode
	output	if_id_t						if_id_o
);

logic					ce_q;
logic [`CPU_PC_W-1:0]	pc_q;
if_id_t					if_id_q;

// Fetch enable rises one clock after reset is released
always_ff @(posedge clk) begin
	if (reset_i) begin
		ce_q <= 1'b0;
	end else begin
		ce_q <= 1'b1;
	end
end

always_ff @(posedge clk) begin
	if (reset_i || !ce_q) begin
		pc_q <= `CPU_RESET_PC;			// first address presented once ce is up
	end else begin
		pc_q <= pc_q + `CPU_PC_W'(4);
	end
end

// A zero word is a NOP for decode
always_ff @(posedge clk) begin
	if (reset_i || !ce_q) begin
		if_id_q <= '0;
	end else begin
		if_id_q.pc <= pc_q;
		if_id_q.inst <= rom_data_i;		// memory answers in the same cycle
	end
end

assign rom_ce_o = ce_q;
assign rom_addr_o = pc_q;
assign if_id_o = if_id_q;

endmodule

// File: logic/cpu_pkg.sv
`include "cpu_cfg.svh"

package cpu_pkg;

	// Primary opcode field
	typedef enum logic [5:0] {
		OP_SPECIAL	= 6'b000000,
		OP_ANDI		= 6'b001100,
		OP_ORI		= 6'b001101,
		OP_XORI		= 6'b001110,
		OP_LUI		= 6'b001111
	} opcode_e;

	// Function field of SPECIAL
	typedef enum logic [5:0] {
		FN_AND		= 6'b100100,
		FN_OR		= 6'b100101,
		FN_XOR		= 6'b100110,
		FN_NOR		= 6'b100111
	} funct_e;

	typedef enum logic [2:0] {
		ALU_NOP,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR
	} alu_op_e;

	typedef struct packed {
		logic							en;
		logic [`CPU_REG_ADDR_W-1:0]	addr;
	} rd_port_t;

	typedef struct packed {
		alu_op_e						alu_op;
		logic [`CPU_DATA_W-1:0]		op1;
		logic [`CPU_DATA_W-1:0]		op2;
		logic [`CPU_REG_ADDR_W-1:0]	wd;
		logic							we;
	} id_ex_t;

	typedef struct packed {
		logic							we;
		logic [`CPU_REG_ADDR_W-1:0]	addr;
		logic [`CPU_DATA_W-1:0]		data;
	} wb_t;

	typedef struct packed {
		logic [`CPU_PC_W-1:0]			pc;
		logic [`CPU_INST_W-1:0]		inst;
	} if_id_t;

endpackage

// File: logic/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Datapath and register widths
`define CPU_DATA_W		32
`define CPU_INST_W		32
`define CPU_PC_W		32

// Register file geometry
`define CPU_REG_ADDR_W	5
`define CPU_REG_NUM		32

// First fetch address after reset
`define CPU_RESET_PC	32'h0000_0000

// Instruction field positions
`define CPU_OP_HI		31
`define CPU_OP_LO		26
`define CPU_RS_HI		25
`define CPU_RS_LO		21
`define CPU_RT_HI		20
`define CPU_RT_LO		16
`define CPU_RD_HI		15
`define CPU_RD_LO		11

`endif
